//--- mmio_pkg.sv
package mmio_pkg;

   ////////////////////////////////////////
   // bus geometry.
   ////////////////////////////////////////

   localparam int DATA_W    = 32;
   localparam int ADR_W     = 24;
   localparam int REG_ADR_W = 4;   // taken from adr bits 18 to 21.

   // slot numbers, matched against adr bits 0 to 7.
   localparam logic [0:7] SLOT_MISC = 8'h00;
   localparam logic [0:7] SLOT_UART = 8'h02;
   localparam logic [0:7] SLOT_KBD  = 8'h04;

   ////////////////////////////////////////
   // payload types.
   ////////////////////////////////////////

   // bit 0 is the msb, as on the bus.
   typedef logic [0:DATA_W-1] bus_word_t;

   typedef struct packed {
      logic [0:6] keycode;
      logic [0:3] shift_state;
   } key_event_t;   // 11 bits.

   typedef logic [0:7] uart_byte_t;

endpackage

//--- mmio_fifo.sv
module mmio_fifo #(
   parameter type payload_t = logic [0:7],
   parameter int  DEPTH     = 4
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   push_i,
   input  payload_t               data_i,
   input  logic                   pop_i,
   output payload_t               data_o,
   output logic                   empty_o,
   output logic                   full_o,
   output logic [$clog2(DEPTH):0] count_o
);

   localparam int PTR_W = $clog2(DEPTH);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign empty_o = (count_o == '0);
   assign full_o  = (count_o == ($clog2(DEPTH) + 1)'(DEPTH));
   assign data_o  = mem[rd_ptr];   // head entry.

   // a push into a full queue only lands when a pop frees the slot.
   assign do_pop  = pop_i && !empty_o;
   assign do_push = push_i && (!full_o || do_pop);

   always_ff @(posedge clk_i) begin
      if (do_push) mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_o <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + PTR_W'(1);
         if (do_pop) rd_ptr <= rd_ptr + PTR_W'(1);
         case ({do_push, do_pop})
            2'b10:   count_o <= count_o + 1'b1;
            2'b01:   count_o <= count_o - 1'b1;
            default: ;
         endcase
      end
   end

   // callers gate their pops on empty.
   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(pop_i && empty_o));

   a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      count_o <= DEPTH);

endmodule

//--- mmio_decode.sv
module mmio_decode (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic [0:mmio_pkg::ADR_W-1]     adr_i,
   input  logic                           cyc_i,
   input  logic                           stb_i,
   input  logic [0:mmio_pkg::DATA_W/8-1]  sel_i,
   input  logic                           we_i,
   input  mmio_pkg::bus_word_t            dat_i,
   output logic                           ack_o,
   output mmio_pkg::bus_word_t            dat_o,

   output logic                           misc_cs_o,
   output logic                           uart_cs_o,
   output logic                           kbd_cs_o,
   input  mmio_pkg::bus_word_t            misc_q_i,
   input  mmio_pkg::bus_word_t            uart_q_i,
   input  mmio_pkg::bus_word_t            kbd_q_i,

   output logic [0:mmio_pkg::REG_ADR_W-1] reg_adr_o,
   output logic                           we_o,
   output logic [0:mmio_pkg::DATA_W/8-1]  sel_o,
   output mmio_pkg::bus_word_t            d_o
);

   logic                access;
   logic [0:7]          slot;
   mmio_pkg::bus_word_t rd_mux;

   assign access    = cyc_i && stb_i && !ack_o;   // one cycle per access.
   assign slot      = adr_i[0:7];
   assign reg_adr_o = adr_i[21 -: mmio_pkg::REG_ADR_W];   // bits 22,23 are byte offset.
   assign we_o      = we_i;
   assign sel_o     = sel_i;
   assign d_o       = dat_i;

   always_comb begin
      misc_cs_o = 1'b0;
      uart_cs_o = 1'b0;
      kbd_cs_o  = 1'b0;
      rd_mux    = '0;   // unmapped slots read zero.
      case (slot)
         mmio_pkg::SLOT_MISC: begin
            misc_cs_o = access;
            rd_mux    = misc_q_i;
         end
         mmio_pkg::SLOT_UART: begin
            uart_cs_o = access;
            rd_mux    = uart_q_i;
         end
         mmio_pkg::SLOT_KBD: begin
            kbd_cs_o = access;
            rd_mux   = kbd_q_i;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) ack_o <= 1'b0;
      else ack_o <= access;
   end

   // captured before any read side effect lands.
   always_ff @(posedge clk_i) begin
      if (access) dat_o <= rd_mux;
   end

   a_cs_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({misc_cs_o, uart_cs_o, kbd_cs_o}));

   a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_o |=> !ack_o);

endmodule

//--- mmio_misc.sv
module mmio_misc (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic [0:mmio_pkg::REG_ADR_W-1] reg_adr_i,
   input  logic                           cs_i,
   input  logic                           we_i,
   input  logic [0:mmio_pkg::DATA_W/8-1]  sel_i,
   input  mmio_pkg::bus_word_t            d_i,
   output mmio_pkg::bus_word_t            q_o,
   output logic                           led_red_o,
   output logic                           led_green_o,
   output logic [0:4]                     sw_reset_o,
   output logic [0:23]                    led1_rgb_o,
   output logic [0:23]                    led2_rgb_o,
   output logic [0:23]                    led3_rgb_o,
   output logic [0:23]                    led4_rgb_o
);

   logic [0:23] rgb [4];
   logic [1:0]  rgb_idx;

   assign rgb_idx    = 2'(reg_adr_i - 4'd2);   // regs 2..5 map to leds 1..4.
   assign led1_rgb_o = rgb[0];
   assign led2_rgb_o = rgb[1];
   assign led3_rgb_o = rgb[2];
   assign led4_rgb_o = rgb[3];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         led_red_o   <= 1'b0;
         led_green_o <= 1'b0;
         sw_reset_o  <= '0;
         for (int i = 0; i < 4; i++) rgb[i] <= '0;
      end else if (cs_i && we_i) begin
         case (reg_adr_i)
            4'd0: if (sel_i[3]) begin
               led_red_o   <= d_i[31];
               led_green_o <= d_i[30];
            end
            4'd1: if (sel_i[3]) sw_reset_o <= d_i[27:31];
            4'd2, 4'd3, 4'd4, 4'd5:
               for (int b = 1; b < 4; b++)   // byte 0 holds nothing.
                  if (sel_i[b]) rgb[rgb_idx][(b-1)*8 +: 8] <= d_i[b*8 +: 8];
            default: ;
         endcase
      end
   end

   always_comb begin
      q_o = '0;
      case (reg_adr_i)
         4'd0: q_o[30:31] = {led_green_o, led_red_o};
         4'd1: q_o[27:31] = sw_reset_o;
         4'd2, 4'd3, 4'd4, 4'd5: q_o[8:31] = rgb[rgb_idx];
         default: ;
      endcase
   end

endmodule

//--- mmio_uart.sv
module mmio_uart #(
   parameter int CLKS_PER_BIT = 8,
   parameter int TX_DEPTH     = 4
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic [0:mmio_pkg::REG_ADR_W-1] reg_adr_i,
   input  logic                           cs_i,
   input  logic                           we_i,
   input  logic [0:mmio_pkg::DATA_W/8-1]  sel_i,
   input  mmio_pkg::bus_word_t            d_i,
   output mmio_pkg::bus_word_t            q_o,
   output logic                           uart_txd_o
);

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

   logic                 tx_push;
   logic                 tx_pop;
   mmio_pkg::uart_byte_t tx_head;
   logic                 tx_empty;
   logic                 tx_full;
   logic                 busy;
   logic [CNT_W-1:0]     clk_cnt;
   logic [3:0]           bit_cnt;
   logic [0:9]           shifter;   // bit 9 is on the line.

   ////////////////////////////////////////
   // register side.
   ////////////////////////////////////////

   // full queue drops the byte, software polls status first.
   assign tx_push = cs_i && we_i && (reg_adr_i == 4'd0) && sel_i[3];

   always_comb begin
      q_o = '0;
      if (reg_adr_i == 4'd1) q_o[29:31] = {busy, tx_empty, tx_full};
   end

   mmio_fifo #(
      .payload_t (mmio_pkg::uart_byte_t),
      .DEPTH     (TX_DEPTH)
   ) u_tx_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (tx_push),
      .data_i  (d_i[24:31]),
      .pop_i   (tx_pop),
      .data_o  (tx_head),
      .empty_o (tx_empty),
      .full_o  (tx_full),
      .count_o ()
   );

   ////////////////////////////////////////
   // serializer.
   ////////////////////////////////////////

   assign tx_pop     = !busy && !tx_empty;
   assign uart_txd_o = shifter[9];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         busy    <= 1'b0;
         clk_cnt <= '0;
         bit_cnt <= '0;
         shifter <= '1;   // line idles high.
      end else if (tx_pop) begin
         busy    <= 1'b1;
         clk_cnt <= '0;
         bit_cnt <= '0;
         shifter <= {1'b1, tx_head, 1'b0};   // stop, data, start; lsb goes first.
      end else if (busy) begin
         if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
               busy <= 1'b0;   // stop bit stays on the line.
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
               shifter <= {1'b1, shifter[0:8]};
            end
         end else begin
            clk_cnt <= clk_cnt + CNT_W'(1);
         end
      end
   end

   a_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !busy |-> uart_txd_o);

endmodule

//--- mmio_keyboard.sv
module mmio_keyboard #(
   parameter int KBD_DEPTH = 4
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic [0:mmio_pkg::REG_ADR_W-1] reg_adr_i,
   input  logic                           cs_i,
   input  logic                           we_i,
   input  logic [0:mmio_pkg::DATA_W/8-1]  sel_i,
   input  mmio_pkg::bus_word_t            d_i,
   output mmio_pkg::bus_word_t            q_o,
   input  logic                           keypress_i,
   input  logic [0:6]                     keycode_i,
   input  logic [0:3]                     shift_state_i,
   output logic                           keyboard_block_o
);

   mmio_pkg::key_event_t         key_hw;
   mmio_pkg::key_event_t         kbd_head;
   logic                         kbd_pop;
   logic                         kbd_empty;
   logic [$clog2(KBD_DEPTH):0]   kbd_count;

   assign key_hw  = '{keycode: keycode_i, shift_state: shift_state_i};
   assign kbd_pop = cs_i && !we_i && (reg_adr_i == 4'd0) && !kbd_empty;   // reads pop the head.

   mmio_fifo #(
      .payload_t (mmio_pkg::key_event_t),
      .DEPTH     (KBD_DEPTH)
   ) u_kbd_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (keypress_i),
      .data_i  (key_hw),
      .pop_i   (kbd_pop),
      .data_o  (kbd_head),
      .empty_o (kbd_empty),
      .full_o  (keyboard_block_o),
      .count_o (kbd_count)
   );

   always_comb begin
      q_o = '0;
      case (reg_adr_i)
         4'd0: if (!kbd_empty) begin
            q_o[0]     = 1'b1;   // valid.
            q_o[21:24] = kbd_head.shift_state;
            q_o[25:31] = kbd_head.keycode;
         end
         4'd1: q_o = mmio_pkg::bus_word_t'(kbd_count);
         default: ;
      endcase
   end

endmodule

//--- mmio_top.sv
module mmio_top #(
   parameter int CLKS_PER_BIT = 8,
   parameter int TX_DEPTH     = 4,
   parameter int KBD_DEPTH    = 4
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic [0:mmio_pkg::ADR_W-1]    adr_i,
   input  logic                          cyc_i,
   input  logic                          stb_i,
   input  logic [0:mmio_pkg::DATA_W/8-1] sel_i,
   input  logic                          we_i,
   input  mmio_pkg::bus_word_t           dat_i,
   output logic                          ack_o,
   output mmio_pkg::bus_word_t           dat_o,
   output logic                          led_red_o,
   output logic                          led_green_o,
   output logic [0:4]                    sw_reset_o,
   output logic [0:23]                   led1_rgb_o,
   output logic [0:23]                   led2_rgb_o,
   output logic [0:23]                   led3_rgb_o,
   output logic [0:23]                   led4_rgb_o,
   output logic                          uart_txd_o,
   input  logic                          keypress_i,
   input  logic [0:6]                    keycode_i,
   input  logic [0:3]                    shift_state_i,
   output logic                          keyboard_block_o
);

   logic                           misc_cs, uart_cs, kbd_cs;
   mmio_pkg::bus_word_t            misc_q, uart_q, kbd_q;
   logic [0:mmio_pkg::REG_ADR_W-1] reg_adr;
   logic                           we;
   logic [0:mmio_pkg::DATA_W/8-1]  sel;
   mmio_pkg::bus_word_t            d;

   mmio_decode u_decode (
      .clk_i, .rst_n_i, .adr_i, .cyc_i, .stb_i, .sel_i, .we_i, .dat_i, .ack_o, .dat_o,
      .misc_cs_o (misc_cs), .uart_cs_o (uart_cs), .kbd_cs_o (kbd_cs),
      .misc_q_i  (misc_q),  .uart_q_i  (uart_q),  .kbd_q_i  (kbd_q),
      .reg_adr_o (reg_adr), .we_o (we), .sel_o (sel), .d_o (d)
   );

   mmio_misc u_misc (
      .clk_i, .rst_n_i, .reg_adr_i (reg_adr), .cs_i (misc_cs), .we_i (we),
      .sel_i (sel), .d_i (d), .q_o (misc_q),
      .led_red_o, .led_green_o, .sw_reset_o,
      .led1_rgb_o, .led2_rgb_o, .led3_rgb_o, .led4_rgb_o
   );

   mmio_uart #(.CLKS_PER_BIT (CLKS_PER_BIT), .TX_DEPTH (TX_DEPTH)) u_uart (
      .clk_i, .rst_n_i, .reg_adr_i (reg_adr), .cs_i (uart_cs), .we_i (we),
      .sel_i (sel), .d_i (d), .q_o (uart_q), .uart_txd_o
   );

   mmio_keyboard #(.KBD_DEPTH (KBD_DEPTH)) u_keyboard (
      .clk_i, .rst_n_i, .reg_adr_i (reg_adr), .cs_i (kbd_cs), .we_i (we),
      .sel_i (sel), .d_i (d), .q_o (kbd_q),
      .keypress_i, .keycode_i, .shift_state_i, .keyboard_block_o
   );

endmodule

//--- tb_mmio.sv
module tb_mmio;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLKS_PER_BIT = 8;
   localparam int TX_DEPTH     = 4;
   localparam int KBD_DEPTH    = 4;

   localparam int N_MISC       = 40;
   localparam int N_UNMAP      = 16;
   localparam int N_UNDEF      = 16;
   localparam int N_KEY_ROUNDS = 12;
   localparam int N_UART       = 10;
   localparam int N_BURST      = TX_DEPTH + 4;
   localparam int N_OPS   = 10 + 2*N_MISC + 2*N_UNMAP + 2*N_UNDEF + 8*N_KEY_ROUNDS
                            + 4*KBD_DEPTH + 2*N_UART + N_BURST;
   localparam int N_BYTES = N_UART + TX_DEPTH + 1;
   localparam int LIMIT   = N_OPS*4 + N_BYTES*10*CLKS_PER_BIT + 2000;

   logic        clk_i = 1'b0;
   logic        rst_n_i;
   logic [23:0] adr_i;
   logic        cyc_i;
   logic        stb_i;
   logic [3:0]  sel_i;
   logic        we_i;
   logic [31:0] dat_i;
   logic        ack_o;
   logic [31:0] dat_o;
   logic        led_red_o;
   logic        led_green_o;
   logic [4:0]  sw_reset_o;
   logic [23:0] led1_rgb_o;
   logic [23:0] led2_rgb_o;
   logic [23:0] led3_rgb_o;
   logic [23:0] led4_rgb_o;
   logic        uart_txd_o;
   logic        keypress_i;
   logic [6:0]  keycode_i;
   logic [3:0]  shift_state_i;
   logic        keyboard_block_o;

   integer      seed = 88655;
   int          cycles = 0;
   int          errors = 0;
   int          test_errs = 0;
   int          tests = 0;
   int          ack_cycles;
   logic        red_m;
   logic        green_m;
   logic [4:0]  swr_m;
   logic [23:0] rgb_m [4];
   logic [10:0] key_q [$];   // {shift_state, keycode}.
   logic [7:0]  tx_exp [$];
   logic [7:0]  rx_got [$];

   mmio_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .TX_DEPTH     (TX_DEPTH),
      .KBD_DEPTH    (KBD_DEPTH)
   ) u_mmio_top (.*);

   always #20 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // reporting.
   ////////////////////////////////////////

   task automatic report_mismatch(input string name, input logic [127:0] exp,
                                  input logic [127:0] act);
      $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
      errors++;
      test_errs++;
   endtask

   task automatic report_error(input string what);
      $display("ERROR %s", what);
      errors++;
      test_errs++;
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (test_errs == 0) $display("%s: ok", name);
      else $display("%s: %0d errors", name, test_errs);
      test_errs = 0;
   endtask

   ////////////////////////////////////////
   // bus and key stimulus.
   ////////////////////////////////////////

   function automatic logic [23:0] slot_adr(input int slot, input int regn);
      return (24'(slot) << 16) | (24'(regn) << 2);   // slot in the top byte.
   endfunction

   task automatic bus_cycle(input logic [23:0] adr, input logic we, input logic [3:0] sel,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      n = 0;
      @(negedge clk_i);
      adr_i = adr;
      we_i  = we;
      sel_i = sel;
      dat_i = wdata;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      do begin
         @(posedge clk_i);
         @(negedge clk_i);
         n++;
      end while (!ack_o && n < 16);
      if (!ack_o) report_error("no acknowledge within 16 cycles");
      rdata      = dat_o;
      ack_cycles = n + 1;   // the master sees ack at the next rising edge.
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic bus_write(input logic [23:0] adr, input logic [3:0] sel,
                            input logic [31:0] d);
      logic [31:0] discard;
      bus_cycle(adr, 1'b1, sel, d, discard);
   endtask

   task automatic bus_read(input logic [23:0] adr, output logic [31:0] d);
      bus_cycle(adr, 1'b0, 4'hf, 32'h0, d);
   endtask

   task automatic press_random_key();
      logic [6:0] code;
      logic [3:0] shift;
      code  = 7'($random(seed));
      shift = 4'($random(seed));
      @(negedge clk_i);
      keypress_i    = 1'b1;
      keycode_i     = code;
      shift_state_i = shift;
      @(negedge clk_i);
      keypress_i = 1'b0;
      if (key_q.size() < KBD_DEPTH) key_q.push_back({shift, code});   // full drops it.
   endtask

   task automatic wait_uart_idle();
      logic [31:0] rd;
      do begin
         bus_read(slot_adr(mmio_pkg::SLOT_UART, 1), rd);
      end while (rd[2] || !rd[1]);   // busy set or queue not empty.
      if (rd !== 32'h2) report_mismatch("uart idle status", 32'h2, rd);
   endtask

   ////////////////////////////////////////
   // misc register model.
   ////////////////////////////////////////

   function automatic logic [31:0] misc_model(input int regn);
      case (regn)
         0: return {30'b0, green_m, red_m};
         1: return {27'b0, swr_m};
         2, 3, 4, 5: return {8'b0, rgb_m[regn-2]};
         default: return 32'b0;
      endcase
   endfunction

   task automatic misc_model_write(input int regn, input logic [3:0] sel, input logic [31:0] d);
      if (regn == 0 && sel[0]) begin
         red_m   = d[0];
         green_m = d[1];
      end
      if (regn == 1 && sel[0]) swr_m = d[4:0];
      if (regn >= 2 && regn <= 5) begin
         for (int b = 0; b < 3; b++)
            if (sel[b]) rgb_m[regn-2][b*8 +: 8] = d[b*8 +: 8];
      end
   endtask

   task automatic check_misc_ports(input string name);
      logic [102:0] exp_p;
      logic [102:0] act_p;
      exp_p = {red_m, green_m, swr_m, rgb_m[0], rgb_m[1], rgb_m[2], rgb_m[3]};
      act_p = {led_red_o, led_green_o, sw_reset_o, led1_rgb_o, led2_rgb_o, led3_rgb_o,
               led4_rgb_o};
      if (act_p !== exp_p) report_mismatch(name, 128'(exp_p), 128'(act_p));
   endtask

   // rebuilds each frame from mid-bit samples.
   initial begin : uart_monitor
      logic [7:0] rx;
      wait (rst_n_i === 1'b1);
      forever begin
         @(negedge clk_i);
         if (!uart_txd_o) begin
            repeat (CLKS_PER_BIT/2) @(negedge clk_i);
            if (uart_txd_o) report_error("uart start bit high at its middle");
            for (int i = 0; i < 8; i++) begin
               repeat (CLKS_PER_BIT) @(negedge clk_i);
               rx[i] = uart_txd_o;   // lsb first.
            end
            repeat (CLKS_PER_BIT) @(negedge clk_i);
            if (!uart_txd_o) report_error("uart stop bit low");
            rx_got.push_back(rx);
         end
      end
   end

   initial begin
      logic [31:0] rd;
      logic [31:0] wd;
      logic [31:0] expv;
      logic [3:0]  sel;
      int          regn;
      int          slot;
      int          n;
      rst_n_i       = 1'b0;
      adr_i         = '0;
      cyc_i         = 1'b0;
      stb_i         = 1'b0;
      sel_i         = '0;
      we_i          = 1'b0;
      dat_i         = '0;
      keypress_i    = 1'b0;
      keycode_i     = '0;
      shift_state_i = '0;
      red_m         = 1'b0;
      green_m       = 1'b0;
      swr_m         = '0;
      for (int i = 0; i < 4; i++) rgb_m[i] = '0;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;

      check_misc_ports("reset ports");
      if (uart_txd_o !== 1'b1) report_mismatch("reset txd", 1, uart_txd_o);
      if (keyboard_block_o !== 1'b0) report_mismatch("reset block", 0, keyboard_block_o);
      bus_read(slot_adr(mmio_pkg::SLOT_UART, 1), rd);
      if (rd !== 32'h2) report_mismatch("reset uart status", 32'h2, rd);
      bus_read(slot_adr(mmio_pkg::SLOT_KBD, 1), rd);
      if (rd !== 32'h0) report_mismatch("reset kbd count", 0, rd);
      finish_test("reset");

      for (int i = 0; i < N_MISC; i++) begin
         regn = {$random(seed)} % 6;
         sel  = 4'($random(seed));
         wd   = $random(seed);
         bus_write(slot_adr(mmio_pkg::SLOT_MISC, regn), sel, wd);
         if (ack_cycles != 2) report_mismatch("misc write ack", 2, ack_cycles);
         misc_model_write(regn, sel, wd);
         check_misc_ports("misc ports");
         bus_read(slot_adr(mmio_pkg::SLOT_MISC, regn), rd);
         if (ack_cycles != 2) report_mismatch("misc read ack", 2, ack_cycles);
         if (rd !== misc_model(regn)) report_mismatch("misc read", misc_model(regn), rd);
      end
      finish_test("misc");

      for (int i = 0; i < N_UNMAP + N_UNDEF; i++) begin
         if (i < N_UNMAP) begin
            do begin
               slot = {$random(seed)} % 256;
            end while (slot == 0 || slot == 2 || slot == 4);
            regn = {$random(seed)} % 16;
         end else begin
            n    = {$random(seed)} % 3;   // misc, uart or keyboard.
            slot = 2 * n;
            regn = (n == 0) ? 6 + {$random(seed)} % 10 : 2 + {$random(seed)} % 14;
         end
         wd = $random(seed);
         bus_write(slot_adr(slot, regn), 4'hf, wd);
         bus_read(slot_adr(slot, regn), rd);
         if (ack_cycles != 2) report_mismatch("unmapped ack", 2, ack_cycles);
         if (rd !== 32'h0) report_mismatch("unmapped read", 0, rd);
      end
      check_misc_ports("unmapped ports");
      if (uart_txd_o !== 1'b1) report_mismatch("unmapped txd", 1, uart_txd_o);
      if (keyboard_block_o !== 1'b0) report_mismatch("unmapped block", 0, keyboard_block_o);
      bus_read(slot_adr(mmio_pkg::SLOT_UART, 1), rd);
      if (rd !== 32'h2) report_mismatch("unmapped uart status", 32'h2, rd);
      finish_test("unmapped");

      for (int i = 0; i < N_KEY_ROUNDS; i++) begin
         n = 1 + {$random(seed)} % KBD_DEPTH;
         repeat (n) press_random_key();
         while (key_q.size() > 0) begin
            expv = {1'b1, 20'b0, key_q.pop_front()};
            bus_read(slot_adr(mmio_pkg::SLOT_KBD, 0), rd);
            if (rd !== expv) report_mismatch("kbd read", expv, rd);
         end
         bus_read(slot_adr(mmio_pkg::SLOT_KBD, 0), rd);
         if (rd !== 32'h0) report_mismatch("kbd empty read", 0, rd);
      end
      repeat (KBD_DEPTH - 1) press_random_key();
      if (keyboard_block_o !== 1'b0) report_mismatch("kbd block early", 0, keyboard_block_o);
      repeat (3) press_random_key();
      if (keyboard_block_o !== 1'b1) report_mismatch("kbd block", 1, keyboard_block_o);
      bus_read(slot_adr(mmio_pkg::SLOT_KBD, 1), rd);
      if (rd !== 32'(KBD_DEPTH)) report_mismatch("kbd count", KBD_DEPTH, rd);
      for (int i = 0; i <= KBD_DEPTH; i++) begin
         expv = 32'h0;
         if (key_q.size() > 0) expv = {1'b1, 20'b0, key_q.pop_front()};
         bus_read(slot_adr(mmio_pkg::SLOT_KBD, 0), rd);
         if (rd !== expv) report_mismatch("kbd drain", expv, rd);
      end
      if (keyboard_block_o !== 1'b0) report_mismatch("kbd unblock", 0, keyboard_block_o);
      finish_test("keyboard");

      for (int i = 0; i < N_UART; i++) begin
         do begin
            bus_read(slot_adr(mmio_pkg::SLOT_UART, 1), rd);
         end while (rd[0]);   // poll until not full.
         wd = $random(seed);
         bus_write(slot_adr(mmio_pkg::SLOT_UART, 0), 4'b0001, wd);
         tx_exp.push_back(wd[7:0]);
      end
      wait_uart_idle();
      // the idle serializer takes the first byte at once, the queue holds the next ones.
      for (int i = 0; i < N_BURST; i++) begin
         wd = $random(seed);
         bus_write(slot_adr(mmio_pkg::SLOT_UART, 0), 4'b0001, wd);
         if (i <= TX_DEPTH) tx_exp.push_back(wd[7:0]);
      end
      bus_read(slot_adr(mmio_pkg::SLOT_UART, 1), rd);
      if (rd !== 32'h5) report_mismatch("uart full status", 32'h5, rd);
      wait_uart_idle();
      if (rx_got.size() != tx_exp.size()) begin
         report_mismatch("uart byte count", tx_exp.size(), rx_got.size());
      end else begin
         foreach (tx_exp[i])
            if (rx_got[i] !== tx_exp[i]) report_mismatch("uart byte", tx_exp[i], rx_got[i]);
      end
      finish_test("uart");

      $display("tests %0d, errors %0d, uart bytes %0d", tests, errors, rx_got.size());
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
mmio_pkg.sv
mmio_fifo.sv
mmio_decode.sv
mmio_misc.sv
mmio_uart.sv
mmio_keyboard.sv
mmio_top.sv
tb_mmio.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the mmio testbench with verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mmio -f filelist.f

./obj_dir/Vtb_mmio | tee sim.log

if grep -qx "Test passed" sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed"
exit 1
